// File: files.f
src/emesh_pkg.sv
src/reg_bank.sv
src/packet_fifo.sv
src/cfg_decoder.sv
src/mesh_cfg_top.sv
test/mesh_cfg_checker.sv
test/mesh_cfg_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mesh_cfg testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mesh_cfg_tb -f files.f -o mesh_cfg_sim
output=$(./obj_dir/mesh_cfg_sim 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "STATUS: PASS"; then
   exit 0
fi
exit 1

// File: src/cfg_decoder.sv
// decodes one packet per cycle; reads answer two edges after accept, stalled whole while full
`timescale 1ns/1ps

module cfg_decoder #(
   parameter emesh_pkg::chip_id_t ID = 12'h810,
   parameter bit                  RX = 1'b0
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  access_in,
   input  emesh_pkg::emesh_pkt_t packet_in,
   input  emesh_pkg::regval_t    cfg_rdata,
   input  emesh_pkg::regval_t    dma_rdata,
   input  emesh_pkg::regval_t    mmu_rdata,
   input  logic                  full,
   output logic                  wait_out,
   output logic                  cfg_en,
   output logic                  dma_en,
   output logic                  mmu_en,
   output logic                  reg_we,
   output emesh_pkg::reg_addr_t  reg_addr,
   output emesh_pkg::regval_t    reg_wdata,
   output logic                  push,
   output emesh_pkg::emesh_pkt_t push_pkt
);

   logic                  stall;
   logic                  accept;
   logic                  match;
   logic                  grp_cfg;
   logic                  grp_mmu;
   logic                  cfg_sel;
   logic                  dma_sel;
   logic                  mmu_sel;
   logic                  bank_hit;
   logic                  fwd_sel;
   emesh_pkg::chip_id_t   dst_id;
   emesh_pkg::group_t     group;
   emesh_pkg::sub_t       sub;
   emesh_pkg::regval_t    rdata_mux;
   logic                  s1_rd;
   logic                  s1_fwd;
   emesh_pkg::emesh_pkt_t s1_pkt;
   emesh_pkg::emesh_pkt_t resp_pkt;

   // back-pressure from the FIFO freezes everything
   assign stall    = full;
   assign wait_out = stall;
   assign accept   = access_in && !stall;

   // address fields
   assign dst_id = packet_in.dstaddr[emesh_pkg::ID_LSB +: 12];
   assign group  = packet_in.dstaddr[emesh_pkg::GROUP_LSB +: 4];
   assign sub    = packet_in.dstaddr[emesh_pkg::SUB_LSB +: 3];

   // our chip, and one of the register groups
   assign match   = accept && (dst_id == ID);
   assign grp_cfg = (group == emesh_pkg::GROUP_CFG);
   assign grp_mmu = (group == emesh_pkg::GROUP_MMU);

   // bank selects, each gated by the link half
   assign cfg_sel = grp_cfg && (sub == {emesh_pkg::CFG_SUB_BASE, RX});
   assign dma_sel = grp_cfg && (sub == emesh_pkg::SUB_DMA)
                    && (packet_in.dstaddr[emesh_pkg::DMA_RX_BIT] == RX);
   assign mmu_sel = grp_mmu && (packet_in.dstaddr[emesh_pkg::MMU_RX_BIT] == RX);

   assign bank_hit = cfg_sel || dma_sel || mmu_sel;
   // register space of this ID but not ours, goes to the other half
   assign fwd_sel  = (grp_cfg || grp_mmu) && !bank_hit;

   // bank strobes, writes land at the accept edge
   assign cfg_en    = match && cfg_sel;
   assign dma_en    = match && dma_sel;
   assign mmu_en    = match && mmu_sel;
   assign reg_we    = accept && packet_in.write;
   assign reg_addr  = packet_in.dstaddr[14:0];
   assign reg_wdata = {packet_in.srcaddr, packet_in.data};

   // idle banks return zero
   assign rdata_mux = cfg_rdata | dma_rdata | mmu_rdata;

   // response goes back to the requester
   always_comb
   begin
      resp_pkt          = s1_pkt;
      resp_pkt.write    = 1'b1;
      resp_pkt.dstaddr  = s1_pkt.srcaddr;
      resp_pkt.srcaddr  = rdata_mux[63:32];
      resp_pkt.data     = rdata_mux[31:0];
   end

   // stage valids and push
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         s1_rd  <= 1'b0;
         s1_fwd <= 1'b0;
         push   <= 1'b0;
      end
      else if (!stall)
      begin
         // stage 1, request registered alongside the bank read
         s1_rd  <= match && bank_hit && !packet_in.write;
         s1_fwd <= match && fwd_sel;
         // stage 2, packet offered to the FIFO
         push   <= s1_rd || s1_fwd;
      end
   end

   // stage payloads
   always_ff @(posedge clk)
   begin
      if (!stall)
      begin
         s1_pkt   <= packet_in;
         // forwarded packets pass through unchanged
         push_pkt <= s1_fwd ? s1_pkt : resp_pkt;
      end
   end

endmodule

// File: src/emesh_pkg.sv
// mesh packet layout and address decode fields; dstaddr bits 31:20 hold the chip ID

package emesh_pkg;

   // mesh address and data words
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;

   // register entry, source address in the upper half and data in the lower half
   typedef logic [63:0] regval_t;

   // top 12 address bits
   typedef logic [11:0] chip_id_t;

   // low 15 address bits, register offset inside the chip
   typedef logic [14:0] reg_addr_t;

   // group nibble at dstaddr[19:16]
   typedef logic [3:0] group_t;

   // subgroup field at dstaddr[10:8]
   typedef logic [2:0] sub_t;

   // one mesh transaction
   // 1 + 2 + 4 + 32 + 32 + 32 = 103 bits
   typedef struct packed {
      logic       write;
      logic [1:0] datamode;
      logic [3:0] ctrlmode;
      addr_t      dstaddr;
      data_t      data;
      addr_t      srcaddr;
   } emesh_pkt_t;

   // field positions inside dstaddr
   localparam int ID_LSB     = 20;
   localparam int GROUP_LSB  = 16;
   localparam int SUB_LSB    = 8;
   // RX/TX half select bit for the mmu group
   localparam int MMU_RX_BIT = 15;
   // RX/TX half select bit for the dma subgroup
   localparam int DMA_RX_BIT = 5;

   // config and dma registers live in group F
   localparam group_t GROUP_CFG = 4'hF;
   // mmu tables live in group E
   localparam group_t GROUP_MMU = 4'hE;

   // dma subgroup code in bits 10:8
   localparam sub_t SUB_DMA = 3'h5;

   // config subgroup, low bit of the code picks the link half
   localparam logic [1:0] CFG_SUB_BASE = 2'b01;

endpackage

// File: src/mesh_cfg_top.sv
// config endpoint for one link half; RX picks the half, FIFO_DEPTH sets output buffering
`timescale 1ns/1ps

module mesh_cfg_top #(
   parameter emesh_pkg::chip_id_t ID         = 12'h810,
   parameter bit                  RX         = 1'b0,
   parameter int                  FIFO_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  access_in,
   input  emesh_pkg::emesh_pkt_t packet_in,
   input  logic                  wait_in,
   output logic                  wait_out,
   output logic                  access_out,
   output emesh_pkg::emesh_pkt_t packet_out
);

   // bank sizes
   localparam int CFG_DEPTH = 8;
   localparam int DMA_DEPTH = 4;
   localparam int MMU_DEPTH = 16;

   logic                  cfg_en;
   logic                  dma_en;
   logic                  mmu_en;
   logic                  reg_we;
   emesh_pkg::reg_addr_t  reg_addr;
   emesh_pkg::regval_t    reg_wdata;
   emesh_pkg::regval_t    cfg_rdata;
   emesh_pkg::regval_t    dma_rdata;
   emesh_pkg::regval_t    mmu_rdata;
   logic                  push;
   emesh_pkg::emesh_pkt_t push_pkt;
   logic                  full;

   // producer
   cfg_decoder #(
      .ID (ID),
      .RX (RX)
   ) cfg_decoder_inst (
      .clk       (clk),
      .rst       (rst),
      .access_in (access_in),
      .packet_in (packet_in),
      .cfg_rdata (cfg_rdata),
      .dma_rdata (dma_rdata),
      .mmu_rdata (mmu_rdata),
      .full      (full),
      .wait_out  (wait_out),
      .cfg_en    (cfg_en),
      .dma_en    (dma_en),
      .mmu_en    (mmu_en),
      .reg_we    (reg_we),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .push      (push),
      .push_pkt  (push_pkt)
   );

   // banks hold their read data on the decoder stall
   reg_bank #(.DEPTH (CFG_DEPTH)) cfg_bank_inst (
      .clk (clk), .rst (rst), .en (cfg_en), .we (reg_we),
      .addr (reg_addr), .wdata (reg_wdata), .hold (wait_out), .rdata (cfg_rdata)
   );

   reg_bank #(.DEPTH (DMA_DEPTH)) dma_bank_inst (
      .clk (clk), .rst (rst), .en (dma_en), .we (reg_we),
      .addr (reg_addr), .wdata (reg_wdata), .hold (wait_out), .rdata (dma_rdata)
   );

   reg_bank #(.DEPTH (MMU_DEPTH)) mmu_bank_inst (
      .clk (clk), .rst (rst), .en (mmu_en), .we (reg_we),
      .addr (reg_addr), .wdata (reg_wdata), .hold (wait_out), .rdata (mmu_rdata)
   );

   // output buffer toward the mesh
   packet_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) packet_fifo_inst (
      .clk        (clk),
      .rst        (rst),
      .push       (push),
      .push_pkt   (push_pkt),
      .wait_in    (wait_in),
      .full       (full),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// File: src/packet_fifo.sv
// synchronous packet FIFO; a push while full is ignored, so the producer must hold on full
`timescale 1ns/1ps

module packet_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  push,
   input  emesh_pkg::emesh_pkt_t push_pkt,
   input  logic                  wait_in,
   output logic                  full,
   output logic                  access_out,
   output emesh_pkg::emesh_pkt_t packet_out
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   emesh_pkg::emesh_pkt_t mem [FIFO_DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [CNT_W-1:0]      count;
   logic                  wr_en;
   logic                  rd_en;

   // flags straight from the count register
   assign full       = (count == CNT_W'(FIFO_DEPTH));
   assign access_out = (count != '0);

   assign wr_en = push && !full;
   // pop on the downstream handshake
   assign rd_en = access_out && !wait_in;

   // head entry, stable until popped
   assign packet_out = mem[rd_ptr];

   // payload storage
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_ptr] <= push_pkt;
      end
   end

   // pointers wrap at FIFO_DEPTH, which need not be a power of two
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en)
         begin
            rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leaves count as is
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: src/reg_bank.sv
// plain 64-bit storage; DEPTH must be a power of two, index sits at bit 2 for 8 entries else bit 3
`timescale 1ns/1ps

module reg_bank #(
   parameter int DEPTH = 8
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                en,
   input  logic                we,
   input  emesh_pkg::reg_addr_t addr,
   input  emesh_pkg::regval_t  wdata,
   input  logic                hold,
   output emesh_pkg::regval_t  rdata
);

   // entry index width and word alignment of the index
   localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int SHIFT = (DEPTH == 8) ? 2 : 3;

   emesh_pkg::regval_t mem [DEPTH];
   logic [IDX_W-1:0]   idx;

   // index bits just above the word alignment
   assign idx = addr[SHIFT +: IDX_W];

   // register storage, cleared on reset
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < DEPTH; i++)
         begin
            mem[i] <= '0;
         end
      end
      else if (en && we)
      begin
         mem[idx] <= wdata;
      end
   end

   // read port, zero when idle so the decoder can OR banks together
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rdata <= '0;
      end
      // frozen while the decoder pipeline is stalled
      else if (!hold)
      begin
         rdata <= (en && !we) ? mem[idx] : '0;
      end
   end

endmodule

// File: test/mesh_cfg_checker.sv
// concurrent handshake checks bound into mesh_cfg_top; needs the internal full and push nets
`timescale 1ns/1ps

module mesh_cfg_checker (
   input logic                  clk,
   input logic                  rst,
   input logic                  wait_in,
   input logic                  wait_out,
   input logic                  access_out,
   input emesh_pkg::emesh_pkt_t packet_out,
   input logic                  full,
   input logic                  push
);

   // both outputs idle in the cycle after a reset edge
   reset_idle: assert property (@(posedge clk) rst |=> (!access_out && !wait_out))
      else $error("access_out or wait_out high in the cycle after reset");

   // head packet frozen while the downstream waits
   hold_stable: assert property (@(posedge clk) disable iff (rst)
      (access_out && wait_in) |=> (access_out && $stable(packet_out)))
      else $error("packet_out changed or vanished while wait_in was high");

   // a pending push into a full FIFO must stall the sender and stay pending
   full_stall: assert property (@(posedge clk) disable iff (rst)
      (full && push) |=> ($past(wait_out) && push))
      else $error("FIFO full with a push pending but wait_out low or the push lost");

   // a push the FIFO takes is visible one cycle later
   push_visible: assert property (@(posedge clk) disable iff (rst)
      (push && !full) |=> access_out)
      else $error("push accepted by the FIFO but access_out stayed low");

endmodule

// File: test/mesh_cfg_tb.sv
// testbench for mesh_cfg_top with ID 12'h810 and RX 0; LCG stimulus with seed 28, FIFO depth 4
`timescale 1ns/1ps

module mesh_cfg_tb;

   localparam emesh_pkg::chip_id_t CHIP_ID = 12'h810;
   localparam bit                  RX      = 1'b0;
   localparam int                  TIMEOUT = 200;

   logic                  clk;
   logic                  rst;
   logic                  access_in;
   emesh_pkg::emesh_pkt_t packet_in;
   logic                  wait_in;
   logic                  wait_out;
   logic                  access_out;
   emesh_pkg::emesh_pkt_t packet_out;

   logic [31:0]           lcg_state;
   // random wait_in when set, else wait_in stays low
   logic                  bp_on;
   int                    mismatches;
   int                    missing;
   int                    extras;
   int                    timeouts;

   // reference registers, key is bank*16 + entry index
   emesh_pkg::regval_t    ref_regs [int];
   // packets still owed by the DUT, oldest first
   emesh_pkg::emesh_pkt_t exp_q [$];

   mesh_cfg_top #(
      .ID         (CHIP_ID),
      .RX         (RX),
      .FIFO_DEPTH (4)
   ) mesh_cfg_top_inst (
      .clk        (clk),
      .rst        (rst),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   // checker sits inside the DUT and sees its FIFO flags
   bind mesh_cfg_top mesh_cfg_checker mesh_cfg_checker_inst (
      .clk (clk), .rst (rst), .wait_in (wait_in), .wait_out (wait_out),
      .access_out (access_out), .packet_out (packet_out), .full (full), .push (push)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // dstaddr of one entry; bank 0 config, 1 dma, 2 mmu
   function automatic emesh_pkg::addr_t entry_addr(input logic [1:0] bank,
                                                  input logic [3:0] idx, input logic rx);
      case (bank)
         2'd0:    return {CHIP_ID, 4'hF, 5'b0, 2'b01, rx, 3'b0, idx[2:0], 2'b0};
         2'd1:    return {CHIP_ID, 4'hF, 5'b0, 3'h5, 2'b0, rx, idx[1:0], 3'b0};
         default: return {CHIP_ID, 4'hE, rx, 4'b0, 3'b0, 1'b0, idx, 3'b0};
      endcase
   endfunction

   function automatic emesh_pkg::emesh_pkt_t random_packet(input emesh_pkg::addr_t dst,
                                                          input logic wr);
      emesh_pkg::emesh_pkt_t pkt;
      logic [31:0]           r;
      r            = next_random();
      pkt.write    = wr;
      pkt.datamode = r[1:0];
      pkt.ctrlmode = r[5:2];
      pkt.dstaddr  = dst;
      pkt.data     = next_random();
      pkt.srcaddr  = next_random();
      return pkt;
   endfunction

   // effect of one accepted packet, straight from the address map
   function automatic void model_accept(input emesh_pkg::emesh_pkt_t pkt);
      emesh_pkg::emesh_pkt_t resp;
      emesh_pkg::regval_t    val;
      logic [3:0]            grp;
      logic [2:0]            sub;
      int                    key;
      grp = pkt.dstaddr[19:16];
      sub = pkt.dstaddr[10:8];
      key = -1;
      // foreign chip, dropped
      if (pkt.dstaddr[31:20] != CHIP_ID)
         return;
      if (grp == 4'hF && sub == {2'b01, RX})
         key = int'(pkt.dstaddr[4:2]);
      else if (grp == 4'hF && sub == 3'h5 && pkt.dstaddr[5] == RX)
         key = 16 + int'(pkt.dstaddr[4:3]);
      else if (grp == 4'hE && pkt.dstaddr[15] == RX)
         key = 32 + int'(pkt.dstaddr[6:3]);
      if (key < 0)
      begin
         // register space of the other half passes through as is
         if (grp == 4'hF || grp == 4'hE)
            exp_q.push_back(pkt);
      end
      else if (pkt.write)
         ref_regs[key] = {pkt.srcaddr, pkt.data};
      else
      begin
         // never-written entries read as zero
         val          = ref_regs.exists(key) ? ref_regs[key] : '0;
         resp         = pkt;
         resp.write   = 1'b1;
         resp.dstaddr = pkt.srcaddr;
         resp.srcaddr = val[63:32];
         resp.data    = val[31:0];
         exp_q.push_back(resp);
      end
   endfunction

   // one falling edge, new wait_in while back-pressure is on
   task automatic next_cycle();
      logic [31:0] r;
      @(negedge clk);
      r       = next_random();
      wait_in = bp_on && (r[9:8] != 2'b00);
   endtask

   // offer a packet until accepted; wait_out is stable between rising edges
   task automatic send_packet(input emesh_pkg::emesh_pkt_t pkt);
      int waited;
      waited    = 0;
      access_in = 1'b1;
      packet_in = pkt;
      while (wait_out && waited < TIMEOUT)
      begin
         next_cycle();
         waited++;
      end
      if (wait_out)
      begin
         $display("timeout at %0t: wait_out stuck high, packet never accepted", $time);
         timeouts++;
      end
      else
         model_accept(pkt);
      next_cycle();
      access_in = 1'b0;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < TIMEOUT)
      begin
         next_cycle();
         waited++;
      end
      if (exp_q.size() != 0)
      begin
         $display("timeout at %0t: output never drained", $time);
         timeouts++;
      end
      // idle tail, so a late extra packet still shows up
      repeat (8) next_cycle();
   endtask

   task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act == exp)
      else
      begin
         $display("ERR %0t packet_out.%s expected %h actual %h", $time, name, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_packet(input emesh_pkg::emesh_pkt_t exp,
                               input emesh_pkg::emesh_pkt_t act);
      check_field("write", 32'(exp.write), 32'(act.write));
      check_field("datamode", 32'(exp.datamode), 32'(act.datamode));
      check_field("ctrlmode", 32'(exp.ctrlmode), 32'(act.ctrlmode));
      check_field("dstaddr", exp.dstaddr, act.dstaddr);
      check_field("data", exp.data, act.data);
      check_field("srcaddr", exp.srcaddr, act.srcaddr);
   endtask

   // pop monitor, compares against the head of the expected queue
   always @(posedge clk)
   begin
      if (!rst && access_out && !wait_in)
      begin
         assert (exp_q.size() != 0)
         else
         begin
            $display("extra packet at %0t: dstaddr %h popped with none expected",
                     $time, packet_out.dstaddr);
            extras++;
         end
         if (exp_q.size() != 0)
            check_packet(exp_q.pop_front(), packet_out);
      end
   end

   initial
   begin
      logic [31:0]      r;
      emesh_pkg::addr_t dst;
      clk        = 1'b0;
      rst        = 1'b1;
      access_in  = 1'b0;
      packet_in  = '0;
      wait_in    = 1'b0;
      bp_on      = 1'b0;
      lcg_state  = 32'd28;
      mismatches = 0;
      missing    = 0;
      extras     = 0;
      timeouts   = 0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // config bank, zero before any write, then even entries written
      for (int i = 0; i < 8; i++)
         send_packet(random_packet(entry_addr(2'd0, 4'(i), RX), 1'b0));
      for (int i = 0; i < 8; i += 2)
         send_packet(random_packet(entry_addr(2'd0, 4'(i), RX), 1'b1));
      for (int i = 0; i < 8; i++)
         send_packet(random_packet(entry_addr(2'd0, 4'(i), RX), 1'b0));

      // dma and mmu at this half, same addresses of the other half forwarded
      for (int b = 1; b < 3; b++)
      begin
         for (int i = 0; i < 16; i++)
         begin
            send_packet(random_packet(entry_addr(2'(b), 4'(i), RX), 1'b1));
            send_packet(random_packet(entry_addr(2'(b), 4'(i), RX), 1'b0));
            send_packet(random_packet(entry_addr(2'(b), 4'(i), !RX), 1'b1));
            send_packet(random_packet(entry_addr(2'(b), 4'(i), !RX), 1'b0));
         end
      end

      // foreign chip ID and an unmapped group, both silently dropped
      for (int i = 0; i < 16; i++)
      begin
         dst         = entry_addr(2'(i % 3), 4'(i), RX);
         dst[31:20]  = 12'h123;
         send_packet(random_packet(dst, 1'b1));
         send_packet(random_packet(dst, 1'b0));
         dst         = entry_addr(2'(i % 3), 4'(i), RX);
         dst[19:16]  = 4'h3;
         send_packet(random_packet(dst, 1'b1));
         send_packet(random_packet(dst, 1'b0));
      end
      // read back everything, contents must be untouched
      for (int b = 0; b < 3; b++)
         for (int i = 0; i < 16; i++)
            send_packet(random_packet(entry_addr(2'(b), 4'(i), RX), 1'b0));
      drain();

      // random mix, back-to-back, with random wait_in
      bp_on = 1'b1;
      repeat (300)
      begin
         r   = next_random();
         dst = entry_addr(r[1:0] % 2'd3, r[12:9], (r[4:2] == 3'd0) ? !RX : RX);
         if (r[7:5] == 3'd0)
            dst[31:20] = 12'h123;
         else if (r[7:5] == 3'd1)
            dst[19:16] = 4'h3;
         send_packet(random_packet(dst, r[8]));
      end
      bp_on = 1'b0;
      drain();

      assert (exp_q.size() == 0)
      else
      begin
         $display("missing packets: %0d expected packets never appeared", exp_q.size());
         missing = exp_q.size();
      end
      $display("errors: mismatches %0d missing %0d extra %0d timeouts %0d",
               mismatches, missing, extras, timeouts);
      if (mismatches + missing + extras + timeouts == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule
